/* hdl/x86_decode_pkg.sv */
`default_nettype none

package x86_decode_pkg;

    // instruction window in bytes, byte 0 in bits 7:0
    localparam int WINDOW_BYTES = 15;

    // displacement size codes
    localparam logic [1:0] DSZ_NONE = 2'd0;
    localparam logic [1:0] DSZ_8    = 2'd1;
    localparam logic [1:0] DSZ_16   = 2'd2;
    localparam logic [1:0] DSZ_32   = 2'd3;

    // immediate size codes
    localparam logic [1:0] ISZ_NONE = 2'd0;
    localparam logic [1:0] ISZ_8    = 2'd1;
    localparam logic [1:0] ISZ_16   = 2'd2;
    localparam logic [1:0] ISZ_32   = 2'd3;

    // immediate class from the opcode table
    // ICLS_V is 32 bits, 16 bits under 0x66
    localparam logic [1:0] ICLS_NONE = 2'd0;
    localparam logic [1:0] ICLS_8    = 2'd1;
    localparam logic [1:0] ICLS_V    = 2'd2;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] mod;
            logic [2:0] reg_op;
            logic [2:0] rm;
        } f;
    } modrm_u;

    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] scale;
            logic [2:0] index;
            logic [2:0] base;
        } f;
    } sib_u;

endpackage

`default_nettype wire

/* hdl/prefix_scan.sv */
`timescale 1ns/1ps
`default_nettype none

module prefix_scan #(
    parameter int MAX_PREFIXES = 4
) (
    input  logic [8*x86_decode_pkg::WINDOW_BYTES-1:0] window,
    output logic [2:0]                                num_prefixes,
    output logic                                      opsize_ovr,
    output logic                                      addrsize_ovr,
    output logic                                      two_byte,
    output logic [7:0]                                opcode
);

    logic       scan_done;
    logic [7:0] first_byte;
    logic [7:0] second_byte;

    // legacy prefix set, segment, size, lock and rep
    function automatic logic is_prefix(input logic [7:0] b);
        case (b)
            8'h26, 8'h2E, 8'h36, 8'h3E,
            8'h64, 8'h65, 8'h66, 8'h67,
            8'hF0, 8'hF2, 8'hF3: is_prefix = 1'b1;
            default:             is_prefix = 1'b0;
        endcase
    endfunction

    // count leading prefixes up to the cap
    always_comb begin
        num_prefixes = 3'd0;
        scan_done    = 1'b0;
        opsize_ovr   = 1'b0;
        addrsize_ovr = 1'b0;
        for (int i = 0; i < MAX_PREFIXES; i++) begin
            if (!scan_done && is_prefix(window[8*i +: 8])) begin
                num_prefixes = num_prefixes + 3'd1;
                if (window[8*i +: 8] == 8'h66) begin
                    opsize_ovr = 1'b1;
                end
                if (window[8*i +: 8] == 8'h67) begin
                    addrsize_ovr = 1'b1;
                end
            end else begin
                scan_done = 1'b1;
            end
        end
    end

    // opcode sits right after the prefixes
    assign first_byte  = window[{num_prefixes, 3'b000} +: 8];
    assign second_byte = window[{num_prefixes + 3'd1, 3'b000} +: 8];

    // 0x0f escape
    assign two_byte = (first_byte == 8'h0F);
    assign opcode   = two_byte ? second_byte : first_byte;

endmodule

`default_nettype wire

/* hdl/opcode_class.sv */
`timescale 1ns/1ps
`default_nettype none

module opcode_class (
    input  logic [7:0] opcode,
    input  logic       two_byte,
    output logic       has_modrm,
    output logic [1:0] imm_class
);
    import x86_decode_pkg::*;

    always_comb begin
        has_modrm = 1'b0;
        imm_class = ICLS_NONE;
        if (two_byte) begin
            // jcc rel32 has no modrm
            if (opcode[7:4] == 4'h8) begin
                imm_class = ICLS_V;
            end else begin
                has_modrm = 1'b1;
            end
        end else begin
            casez (opcode)
                // alu block, low bits 0 to 3
                8'b00??_?0??: begin
                    has_modrm = 1'b1;
                end
                // alu al, imm8
                8'b00??_?100: begin
                    imm_class = ICLS_8;
                end
                // alu eax, imm
                8'b00??_?101: begin
                    imm_class = ICLS_V;
                end
                8'h80, 8'h83, 8'h6B, 8'hC6: begin
                    has_modrm = 1'b1;
                    imm_class = ICLS_8;
                end
                8'h81, 8'h69, 8'hC7: begin
                    has_modrm = 1'b1;
                    imm_class = ICLS_V;
                end
                // mov r/m forms
                8'b1000_10??: begin
                    has_modrm = 1'b1;
                end
                // push imm8, mov r8, imm8
                8'h6A, 8'b1011_0???: begin
                    imm_class = ICLS_8;
                end
                // push imm, mov r32, imm
                8'h68, 8'b1011_1???: begin
                    imm_class = ICLS_V;
                end
                default: begin
                    has_modrm = 1'b0;
                    imm_class = ICLS_NONE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* hdl/disp_size_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module disp_size_decode (
    input  x86_decode_pkg::modrm_u modrm,
    input  x86_decode_pkg::sib_u   sib,
    input  logic                   addrsize_ovr,
    input  logic                   has_modrm,
    output logic [1:0]             d_size,
    output logic                   has_sib
);
    import x86_decode_pkg::*;

    always_comb begin
        d_size  = DSZ_NONE;
        has_sib = 1'b0;
        // mod 11 is register direct
        if (has_modrm && modrm.f.mod != 2'b11) begin
            if (addrsize_ovr) begin
                // 16-bit forms, never a sib
                case (modrm.f.mod)
                    2'b01:   d_size = DSZ_8;
                    2'b10:   d_size = DSZ_16;
                    default: d_size = (modrm.f.rm == 3'b110) ? DSZ_16 : DSZ_NONE;
                endcase
            end else begin
                has_sib = (modrm.f.rm == 3'b100);
                case (modrm.f.mod)
                    2'b01: d_size = DSZ_8;
                    2'b10: d_size = DSZ_32;
                    default: begin
                        // disp32 only, or sib with no base
                        if (modrm.f.rm == 3'b101 || (has_sib && sib.f.base == 3'b101)) begin
                            d_size = DSZ_32;
                        end
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/disp_imm_select.sv */
`timescale 1ns/1ps
`default_nettype none

module disp_imm_select #(
    parameter int MAX_PREFIXES = 4
) (
    input  logic [8*x86_decode_pkg::WINDOW_BYTES-1:0] window,
    input  logic [2:0]                                num_prefixes,
    input  logic                                      two_byte,
    input  logic                                      opsize_ovr,
    input  logic                                      addrsize_ovr,
    input  logic                                      has_modrm,
    input  logic [1:0]                                imm_class,
    output logic [31:0]                               disp,
    output logic [31:0]                               imm,
    output logic [1:0]                                disp_size,
    output logic [1:0]                                imm_size,
    output logic [3:0]                                length
);
    import x86_decode_pkg::*;

    // zero bytes past the window keep 4-byte reads in range
    localparam int EXT_BYTES = WINDOW_BYTES + MAX_PREFIXES;
    localparam int OFF_W     = $clog2(EXT_BYTES);

    logic [8*EXT_BYTES-1:0] win_ext;
    logic [OFF_W-1:0]       modrm_off;
    logic [OFF_W-1:0]       disp_off;
    logic [OFF_W-1:0]       imm_off;
    logic [OFF_W-1:0]       len_full;
    logic [7:0]             modrm_byte;
    logic [7:0]             sib_byte;
    logic                   has_sib;
    logic [2:0]             disp_bytes;
    logic [2:0]             imm_bytes;
    logic [31:0]            disp_raw;
    logic [31:0]            imm_raw;

    // little-endian value of nbytes, sign-extended
    function automatic logic [31:0] sext(input logic [2:0] nbytes, input logic [31:0] raw);
        case (nbytes)
            3'd1:    sext = {{24{raw[7]}}, raw[7:0]};
            3'd2:    sext = {{16{raw[15]}}, raw[15:0]};
            3'd4:    sext = raw;
            default: sext = 32'd0;
        endcase
    endfunction

    assign win_ext = {{(8*MAX_PREFIXES){1'b0}}, window};

    //////////////////////////////
    // modrm and sib
    //////////////////////////////

    assign modrm_off  = OFF_W'(num_prefixes) + OFF_W'(two_byte) + OFF_W'(1);
    assign modrm_byte = win_ext[{modrm_off, 3'b000} +: 8];
    assign sib_byte   = win_ext[{modrm_off + OFF_W'(1), 3'b000} +: 8];

    disp_size_decode dsz0 (
        .modrm        (modrm_byte),
        .sib          (sib_byte),
        .addrsize_ovr (addrsize_ovr),
        .has_modrm    (has_modrm),
        .d_size       (disp_size),
        .has_sib      (has_sib)
    );

    //////////////////////////////
    // sizes
    //////////////////////////////

    always_comb begin
        case (disp_size)
            DSZ_8:   disp_bytes = 3'd1;
            DSZ_16:  disp_bytes = 3'd2;
            DSZ_32:  disp_bytes = 3'd4;
            default: disp_bytes = 3'd0;
        endcase
    end

    // operand-size prefix shrinks the v class
    always_comb begin
        case (imm_class)
            ICLS_8:  imm_size = ISZ_8;
            ICLS_V:  imm_size = opsize_ovr ? ISZ_16 : ISZ_32;
            default: imm_size = ISZ_NONE;
        endcase
        case (imm_size)
            ISZ_8:   imm_bytes = 3'd1;
            ISZ_16:  imm_bytes = 3'd2;
            ISZ_32:  imm_bytes = 3'd4;
            default: imm_bytes = 3'd0;
        endcase
    end

    //////////////////////////////
    // byte selection
    //////////////////////////////

    // disp after modrm and sib, imm after disp
    assign disp_off = modrm_off + OFF_W'(has_modrm) + OFF_W'(has_sib);
    assign imm_off  = disp_off + OFF_W'(disp_bytes);

    assign disp_raw = win_ext[{disp_off, 3'b000} +: 32];
    assign imm_raw  = win_ext[{imm_off, 3'b000} +: 32];

    assign disp = sext(disp_bytes, disp_raw);
    assign imm  = sext(imm_bytes, imm_raw);

    // at most 15 for any legal combination
    assign len_full = imm_off + OFF_W'(imm_bytes);
    assign length   = len_full[3:0];

endmodule

`default_nettype wire

/* hdl/decode_front.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_front #(
    parameter int MAX_PREFIXES = 4
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      valid_in,
    input  logic [8*x86_decode_pkg::WINDOW_BYTES-1:0] window,
    output logic                                      valid_out,
    output logic [3:0]                                length,
    output logic [31:0]                               disp,
    output logic [31:0]                               imm,
    output logic [1:0]                                disp_size,
    output logic [1:0]                                imm_size
);
    import x86_decode_pkg::*;

    logic [8*WINDOW_BYTES-1:0] win_q;
    logic                      valid_q;

    logic [2:0]  num_prefixes;
    logic        opsize_ovr;
    logic        addrsize_ovr;
    logic        two_byte;
    logic [7:0]  opcode;
    logic        has_modrm;
    logic [1:0]  imm_class;
    logic [31:0] d_disp;
    logic [31:0] d_imm;
    logic [1:0]  d_disp_size;
    logic [1:0]  d_imm_size;
    logic [3:0]  d_length;

    //////////////////////////////
    // valid pipeline
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            valid_out <= 1'b0;
        end else begin
            valid_q   <= valid_in;
            valid_out <= valid_q;
        end
    end

    // stage 1 window, stage 2 results
    always_ff @(posedge clk) begin
        if (valid_in) begin
            win_q <= window;
        end
        if (valid_q) begin
            length    <= d_length;
            disp      <= d_disp;
            imm       <= d_imm;
            disp_size <= d_disp_size;
            imm_size  <= d_imm_size;
        end
    end

    //////////////////////////////
    // decode on win_q
    //////////////////////////////

    prefix_scan #(
        .MAX_PREFIXES (MAX_PREFIXES)
    ) pfx0 (
        .window       (win_q),
        .num_prefixes (num_prefixes),
        .opsize_ovr   (opsize_ovr),
        .addrsize_ovr (addrsize_ovr),
        .two_byte     (two_byte),
        .opcode       (opcode)
    );

    opcode_class ocls0 (
        .opcode    (opcode),
        .two_byte  (two_byte),
        .has_modrm (has_modrm),
        .imm_class (imm_class)
    );

    disp_imm_select #(
        .MAX_PREFIXES (MAX_PREFIXES)
    ) sel0 (
        .window       (win_q),
        .num_prefixes (num_prefixes),
        .two_byte     (two_byte),
        .opsize_ovr   (opsize_ovr),
        .addrsize_ovr (addrsize_ovr),
        .has_modrm    (has_modrm),
        .imm_class    (imm_class),
        .disp         (d_disp),
        .imm          (d_imm),
        .disp_size    (d_disp_size),
        .imm_size     (d_imm_size),
        .length       (d_length)
    );

endmodule

`default_nettype wire

/* bench/decode_front_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_front_properties (
    input logic        clk,
    input logic        reset,
    input logic        valid_in,
    input logic        valid_out,
    input logic [3:0]  length,
    input logic [31:0] disp,
    input logic [1:0]  disp_size
);
    import x86_decode_pkg::*;

    valid_low_after_reset: assert property (@(posedge clk) reset |=> !valid_out)
        else $error("valid_out high in the cycle after reset");

    // fixed two-cycle valid pipeline once reset is two cycles gone
    valid_two_cycles: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) && !$past(reset, 2) |-> valid_out == $past(valid_in, 2))
        else $error("valid_out does not follow valid_in by two cycles");

    // a sum past 15 wraps the 4-bit length to zero
    length_in_range: assert property (@(posedge clk) valid_out |-> length != 4'd0)
        else $error("length wrapped past 15");

    no_disp_is_zero: assert property (@(posedge clk)
        valid_out && disp_size == DSZ_NONE |-> disp == 32'd0)
        else $error("disp nonzero without a displacement");

endmodule

bind decode_front decode_front_properties props0 (
    .clk       (clk),
    .reset     (reset),
    .valid_in  (valid_in),
    .valid_out (valid_out),
    .length    (length),
    .disp      (disp),
    .disp_size (disp_size)
);

`default_nettype wire

/* bench/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH
`default_nettype none

// n bytes little-endian from byte pos, sign-extended
function automatic logic [31:0] field_at(input logic [8*WINDOW_BYTES+31:0] wx,
                                         input int pos, input int n);
    logic [31:0] v;
    v = 32'd0;
    for (int k = 0; k < n; k++) begin
        v[8*k +: 8] = wx[8*(pos+k) +: 8];
    end
    if (n > 0 && n < 4 && v[8*n-1]) begin
        v = v - (32'd1 << (8*n));
    end
    return v;
endfunction

// walks the window byte by byte: {length, disp, imm, disp_size, imm_size}
function automatic logic [71:0] decode_ref(input logic [8*WINDOW_BYTES-1:0] w);
    logic [8*WINDOW_BYTES+31:0] wx;
    modrm_u                     m;
    logic [7:0]                 op;
    logic                       osz;
    logic                       asz;
    logic                       two;
    logic                       has_m;
    logic [1:0]                 icls;
    int                         pos;
    int                         dlen;
    int                         ilen;
    logic [31:0]                dv;
    logic [31:0]                iv;
    wx  = {32'd0, w};
    pos = 0;
    osz = 1'b0;
    asz = 1'b0;
    while (pos < MAX_PREFIXES && wx[8*pos +: 8] inside {8'h26, 8'h2E, 8'h36, 8'h3E, 8'h64,
            8'h65, 8'h66, 8'h67, 8'hF0, 8'hF2, 8'hF3}) begin
        osz |= (wx[8*pos +: 8] == 8'h66);
        asz |= (wx[8*pos +: 8] == 8'h67);
        pos++;
    end
    two   = (wx[8*pos +: 8] == 8'h0F);
    pos   = pos + (two ? 2 : 1);
    op    = wx[8*(pos-1) +: 8];
    has_m = 1'b0;
    icls  = ICLS_NONE;
    if (two) begin
        has_m = !(op inside {[8'h80:8'h8F]});
        icls  = has_m ? ICLS_NONE : ICLS_V;
    end else if (op < 8'h40) begin
        has_m = (op[2:0] < 3'd4);
        icls  = (op[2:0] == 3'd4) ? ICLS_8 : (op[2:0] == 3'd5) ? ICLS_V : ICLS_NONE;
    end else if (op inside {8'h80, 8'h83, 8'h6B, 8'hC6}) begin
        has_m = 1'b1;
        icls  = ICLS_8;
    end else if (op inside {8'h81, 8'h69, 8'hC7}) begin
        has_m = 1'b1;
        icls  = ICLS_V;
    end else if (op inside {[8'h88:8'h8B]}) begin
        has_m = 1'b1;
    end else if (op inside {8'h6A, [8'hB0:8'hB7]}) begin
        icls = ICLS_8;
    end else if (op inside {8'h68, [8'hB8:8'hBF]}) begin
        icls = ICLS_V;
    end
    dlen = 0;
    if (has_m) begin
        m.raw = wx[8*pos +: 8];
        pos++;
        if (m.f.mod == 2'b01) dlen = 1;
        else if (m.f.mod == 2'b10) dlen = asz ? 2 : 4;
        else if (m.f.mod == 2'b00 && asz && m.f.rm == 3'b110) dlen = 2;
        else if (m.f.mod == 2'b00 && !asz && m.f.rm == 3'b101) dlen = 4;
        // sib only in 32-bit addressing
        if (!asz && m.f.mod != 2'b11 && m.f.rm == 3'b100) begin
            if (m.f.mod == 2'b00 && wx[8*pos +: 3] == 3'b101) dlen = 4;
            pos++;
        end
    end
    dv   = field_at(wx, pos, dlen);
    pos  = pos + dlen;
    ilen = (icls == ICLS_8) ? 1 : (icls == ICLS_V) ? (osz ? 2 : 4) : 0;
    iv   = field_at(wx, pos, ilen);
    pos  = pos + ilen;
    return {4'(pos), dv, iv,
            (dlen == 0) ? DSZ_NONE : (dlen == 1) ? DSZ_8 : (dlen == 2) ? DSZ_16 : DSZ_32,
            (ilen == 0) ? ISZ_NONE : (ilen == 1) ? ISZ_8 : (ilen == 2) ? ISZ_16 : ISZ_32};
endfunction

`default_nettype wire
`endif

/* bench/decode_front_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_front_tb;
    import x86_decode_pkg::*;

    localparam int MAX_PREFIXES = 4;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int RUN_A        = 300;
    localparam int MID_RESET    = 3;
    localparam int RUN_B        = 250;
    localparam int DRAIN        = 5;
    localparam int TOTAL_CYCLES = RESET_CYCLES + RUN_A + MID_RESET + RUN_B + DRAIN;
    localparam logic [87:0] PREFIXES = {8'hF3, 8'hF2, 8'hF0, 8'h67, 8'h66, 8'h65,
                                        8'h64, 8'h3E, 8'h36, 8'h2E, 8'h26};

    logic                      clk;
    logic                      reset;
    logic                      valid_in;
    logic [8*WINDOW_BYTES-1:0] window;
    logic                      valid_out;
    logic [3:0]                length;
    logic [31:0]               disp;
    logic [31:0]               imm;
    logic [1:0]                disp_size;
    logic [1:0]                imm_size;

    logic [31:0] rng_state = 32'hcb190b4c;
    logic [71:0] exp_q[$];
    int          due_q[$];
    int          cycle_cnt = 0;
    int          n_checked = 0;
    logic        last_valid = 1'b0;

    `include "decode_model.svh"

    decode_front #(
        .MAX_PREFIXES (MAX_PREFIXES)
    ) dut0 (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (valid_in),
        .window    (window),
        .valid_out (valid_out),
        .length    (length),
        .disp      (disp),
        .imm       (imm),
        .disp_size (disp_size),
        .imm_size  (imm_size)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "decode_front_tb stopped");
    endtask

    task automatic check_word(input string name, input logic [31:0] expv, input logic [31:0] actv);
        if (actv !== expv) begin
            abort_run($sformatf("ERROR %s expected %08h actual %08h", name, expv, actv));
        end
    endtask

    task automatic check_size(input string name, input logic [1:0] expv, input logic [1:0] actv);
        if (actv !== expv) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expv, actv));
        end
    endtask

    task automatic check_len(input string name, input logic [3:0] expv, input logic [3:0] actv);
        if (actv !== expv) begin
            abort_run($sformatf("ERROR %s expected %0d actual %0d", name, expv, actv));
        end
    endtask

    function automatic logic [7:0] rand_byte();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state[23:16];
    endfunction

    function automatic logic [8*WINDOW_BYTES-1:0] build_window();
        logic [8*WINDOW_BYTES-1:0] w;
        logic [31:0]               tbl;
        logic [7:0]                sel;
        logic [7:0]                r;
        logic [7:0]                op;
        int                        pos;
        int                        npfx;
        for (int i = 0; i < WINDOW_BYTES; i++) begin
            w[8*i +: 8] = rand_byte();
        end
        // one past the cap now and then
        npfx = int'(rand_byte()) % (MAX_PREFIXES + 2);
        for (pos = 0; pos < npfx; pos++) begin
            r = rand_byte();
            w[8*pos +: 8] = PREFIXES[8*(int'(r) % 11) +: 8];
        end
        sel = rand_byte();
        r   = rand_byte();
        case (sel[2:0])
            3'd0: op = r[7] ? r : {2'b00, r[5:0]};
            3'd1: begin
                tbl = 32'hC66B_8380;
                op  = tbl[8*r[1:0] +: 8];
            end
            3'd2: begin
                tbl = 32'hC769_8181;
                op  = tbl[8*r[1:0] +: 8];
            end
            3'd3: op = {6'b100010, r[1:0]};
            3'd4: op = r[3] ? 8'h6A : {5'b10110, r[2:0]};
            3'd5: op = r[3] ? 8'h68 : {5'b10111, r[2:0]};
            3'd6: op = {4'h8, r[3:0]};
            default: op = r;
        endcase
        // two-byte forms
        if (sel[2:1] == 2'b11) begin
            w[8*pos +: 8] = 8'h0F;
            pos++;
        end
        w[8*pos +: 8] = op;
        pos++;
        // steer rm and sib base toward the special encodings
        r = rand_byte();
        if (r[2:0] < 3'd3) begin
            w[8*pos +: 3] = 3'd4 + r[2:0];
        end
        if (r[3]) begin
            w[8*(pos+1) +: 3] = 3'b101;
        end
        return w;
    endfunction

    //////////////////////////////
    // stimulus
    //////////////////////////////

    task automatic run_stream(input int cycles);
        logic [8*WINDOW_BYTES-1:0] w;
        logic                      v;
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            v = (rand_byte() > 8'd48);
            w = build_window();
            if (v) begin
                exp_q.push_back(decode_ref(w));
                // this is edge cycle_cnt+1, result visible after two more
                due_q.push_back(cycle_cnt + 3);
            end
            reset      <= 1'b0;
            valid_in   <= v;
            window     <= w;
            last_valid = v;
        end
    endtask

    task automatic apply_reset(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(posedge clk);
            // window taken at this edge is still in stage 1 when reset hits
            if (i == 0 && last_valid) begin
                void'(exp_q.pop_back());
                void'(due_q.pop_back());
            end
            reset    <= 1'b1;
            valid_in <= (rand_byte() > 8'd128);
            window   <= build_window();
        end
        last_valid = 1'b0;
    endtask

    initial begin
        reset    = 1'b1;
        valid_in = 1'b0;
        window   = '0;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        run_stream(RUN_A);
        apply_reset(MID_RESET);
        run_stream(RUN_B);
        @(posedge clk);
        valid_in <= 1'b0;
        repeat (DRAIN - 1) @(posedge clk);
        if (exp_q.size() != 0) begin
            abort_run($sformatf("%0d expected results never came out", exp_q.size()));
        end else begin
            $display("checked %0d results", n_checked);
            $display("RESULT: PASS");
            $finish;
        end
    end

    // compare on the falling edge
    initial begin
        logic [71:0] e;
        int          due;
        forever begin
            @(negedge clk);
            if (valid_out === 1'b1) begin
                if (exp_q.size() == 0) begin
                    abort_run("valid_out went high with no accepted window waiting");
                end else begin
                    e   = exp_q.pop_front();
                    due = due_q.pop_front();
                    if (cycle_cnt != due) begin
                        abort_run($sformatf("ERROR item %0d latency expected cycle %0d actual %0d",
                                            n_checked, due, cycle_cnt));
                    end
                    check_len($sformatf("item %0d length", n_checked), e[71:68], length);
                    check_word($sformatf("item %0d disp", n_checked), e[67:36], disp);
                    check_word($sformatf("item %0d imm", n_checked), e[35:4], imm);
                    check_size($sformatf("item %0d disp_size", n_checked), e[3:2], disp_size);
                    check_size($sformatf("item %0d imm_size", n_checked), e[1:0], imm_size);
                    n_checked++;
                end
            end
        end
    end

    initial begin
        #((TOTAL_CYCLES + 20) * CLK_PERIOD);
        abort_run("watchdog expired before the test sequence finished");
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+bench
hdl/x86_decode_pkg.sv
hdl/prefix_scan.sv
hdl/opcode_class.sv
hdl/disp_size_decode.sv
hdl/disp_imm_select.sv
hdl/decode_front.sv
bench/decode_front_properties.sv
bench/decode_front_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= decode_front_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= verilog.f
VFLAGS    ?= --binary --assert --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := $(wildcard bench/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source, header or the file list changes
$(SIM): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
